//--- rtl/cmd_dispatch.sv
`timescale 1ns/100ps

module cmd_dispatch #(
   parameter int NUM_LANES = 4
) (
   input  logic                        clk,
   input  logic                        i_reset,
   input  logic                        i_cmd_valid,
   input  serpc_ctrl_pkg::cmd_t        i_cmd,
   output logic                        o_cmd_ready,
   input  logic [NUM_LANES-1:0]        i_credit,
   output serpc_ctrl_pkg::ser_stream_t o_stream
);

   logic [NUM_LANES-1:0]       credit_q;
   logic                       busy_q;
   logic [4:0]                 bit_cnt_q;
   serpc_ctrl_pkg::lane_id_t   lane_q;
   serpc_ctrl_pkg::flow_kind_e kind_q;
   serpc_ctrl_pkg::xlen_t      offset_sr;
   serpc_ctrl_pkg::xlen_t      base_sr;
   logic                       lane_ok;
   logic                       accept;

   // lane numbers above the built lanes are never accepted.
   assign lane_ok     = int'(i_cmd.lane) < NUM_LANES;
   assign o_cmd_ready = !busy_q && lane_ok && credit_q[i_cmd.lane];
   assign accept      = i_cmd_valid && o_cmd_ready;

   // one credit per lane.
   always_ff @(posedge clk) begin
      if (i_reset) begin
         credit_q <= '1;
      end else begin
         for (int i = 0; i < NUM_LANES; i++) begin
            if (accept && (int'(i_cmd.lane) == i)) begin
               credit_q[i] <= 1'b0;
            end else if (i_credit[i]) begin
               credit_q[i] <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         busy_q    <= 1'b0;
         bit_cnt_q <= '0;
      end else if (accept) begin
         busy_q    <= 1'b1;
         bit_cnt_q <= '0;
      end else if (busy_q) begin
         bit_cnt_q <= bit_cnt_q + 5'd1;
         if (bit_cnt_q == 5'd31) begin
            busy_q <= 1'b0;
         end
      end
   end

   // payload shifts out lsb first.
   always_ff @(posedge clk) begin
      if (accept) begin
         lane_q    <= i_cmd.lane;
         kind_q    <= i_cmd.kind;
         offset_sr <= i_cmd.offset;
         base_sr   <= i_cmd.base;
      end else if (busy_q) begin
         offset_sr <= {1'b0, offset_sr[31:1]};
         base_sr   <= {1'b0, base_sr[31:1]};
      end
   end

   assign o_stream = '{
      valid:      busy_q,
      first:      busy_q && (bit_cnt_q == 5'd0),
      last:       busy_q && (bit_cnt_q == 5'd31),
      lane:       lane_q,
      kind:       kind_q,
      offset_bit: offset_sr[0],
      base_bit:   base_sr[0]
   };

endmodule

//--- rtl/fetch_arbiter.sv
`timescale 1ns/100ps

module fetch_arbiter #(
   parameter int NUM_LANES = 4
) (
   input  logic                      clk,
   input  logic                      i_reset,
   input  serpc_bus_pkg::fetch_req_t i_req [NUM_LANES],
   output logic [NUM_LANES-1:0]      o_done,
   output logic [NUM_LANES-1:0]      o_credit,
   output logic                      o_ibus_cyc,
   output serpc_bus_pkg::iadr_t      o_ibus_adr,
   input  logic                      i_ibus_ack,
   output logic                      o_fetch_valid,
   output serpc_bus_pkg::fetch_rec_t o_fetch
);

   typedef enum logic {
      ARB_IDLE,
      ARB_BUSY
   } arb_state_e;

   arb_state_e               state_q;
   serpc_ctrl_pkg::lane_id_t rr_ptr_q;
   serpc_ctrl_pkg::lane_id_t grant_lane;
   logic                     grant_found;
   serpc_ctrl_pkg::lane_id_t lane_q;
   serpc_bus_pkg::iadr_t     adr_q;
   logic                     misalign_q;
   logic                     complete;
   logic [NUM_LANES-1:0]     done_vec;

   // search down so the lowest offset from the pointer wins.
   always_comb begin
      int idx;
      grant_found = 1'b0;
      grant_lane  = '0;
      for (int k = NUM_LANES - 1; k >= 0; k--) begin
         idx = (int'(rr_ptr_q) + k) % NUM_LANES;
         if (i_req[idx].req) begin
            grant_found = 1'b1;
            grant_lane  = serpc_ctrl_pkg::lane_id_t'(idx);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state_q  <= ARB_IDLE;
         rr_ptr_q <= '0;
      end else begin
         case (state_q)
            ARB_IDLE: begin
               if (grant_found) begin
                  state_q  <= ARB_BUSY;
                  rr_ptr_q <= serpc_ctrl_pkg::lane_id_t'((int'(grant_lane) + 1) % NUM_LANES);
               end
            end
            default: begin
               if (i_ibus_ack) begin
                  state_q <= ARB_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == ARB_IDLE && grant_found) begin
         lane_q     <= grant_lane;
         adr_q      <= i_req[grant_lane].adr;
         misalign_q <= i_req[grant_lane].misalign;
      end
   end

   assign o_ibus_cyc = (state_q == ARB_BUSY);
   assign o_ibus_adr = adr_q;
   assign complete   = o_ibus_cyc && i_ibus_ack;

   // one completion event, seen by the lane and by the dispatcher.
   always_comb begin
      done_vec = '0;
      if (complete) begin
         done_vec[lane_q] = 1'b1;
      end
   end

   assign o_done        = done_vec;
   assign o_credit      = done_vec;
   assign o_fetch_valid = complete;
   assign o_fetch       = '{lane: lane_q, adr: adr_q, misalign: misalign_q};

endmodule

//--- rtl/pc_lane.sv
`timescale 1ns/100ps

module pc_lane #(
   parameter int unsigned           LANE_ID  = 0,
   parameter serpc_ctrl_pkg::xlen_t RESET_PC = 32'd8
) (
   input  logic                        clk,
   input  logic                        i_reset,
   input  serpc_ctrl_pkg::ser_stream_t i_stream,
   input  logic                        i_done,
   output serpc_bus_pkg::fetch_req_t   o_fetch
);

   serpc_ctrl_pkg::xlen_t pc_q;
   logic                  sel;
   logic                  first_r;
   logic                  first_2r;
   logic                  word_end;
   logic                  pc_bit;
   logic                  plus4_sum;
   logic                  off_a;
   logic                  off_b;
   logic                  off_sum;
   logic                  target_bit;
   logic                  align_clr;
   logic                  new_bit;
   logic                  req_q;
   logic                  misalign_q;

   assign sel      = i_stream.valid &&
                     (i_stream.lane == serpc_ctrl_pkg::lane_id_t'(LANE_ID));
   assign word_end = sel & i_stream.last;
   assign pc_bit   = sel & pc_q[0];

   // first delayed twice marks bit 2, which is the constant four.
   always_ff @(posedge clk) begin
      if (i_reset) begin
         first_r  <= 1'b0;
         first_2r <= 1'b0;
      end else begin
         first_r  <= sel & i_stream.first;
         first_2r <= first_r;
      end
   end

   ser_add u_plus_4 (
      .clk     (clk),
      .i_reset (i_reset),
      .i_a     (pc_bit),
      .i_b     (first_2r),
      .i_clr   (word_end),
      .o_q     (plus4_sum)
   );

   // jalr adds to the base value, the other kinds to the pc.
   assign off_a = (i_stream.kind == serpc_ctrl_pkg::FLOW_JALR) ?
                  (sel & i_stream.base_bit) : pc_bit;
   assign off_b = sel & i_stream.offset_bit;

   ser_add u_plus_offset (
      .clk     (clk),
      .i_reset (i_reset),
      .i_a     (off_a),
      .i_b     (off_b),
      .i_clr   (word_end),
      .o_q     (off_sum)
   );

   always_comb begin
      case (i_stream.kind)
         serpc_ctrl_pkg::FLOW_SEQ:  target_bit = plus4_sum;
         serpc_ctrl_pkg::FLOW_JUMP: target_bit = off_sum;
         serpc_ctrl_pkg::FLOW_JALR: target_bit = off_sum;
         default:                   target_bit = i_stream.base_bit;
      endcase
   end

   // jump targets lose bit 0.
   assign align_clr = (i_stream.kind != serpc_ctrl_pkg::FLOW_SEQ) & i_stream.first;
   assign new_bit   = target_bit & ~align_clr;

   // rotate one bit per streamed cycle, new bits enter at the top.
   always_ff @(posedge clk) begin
      if (i_reset) begin
         pc_q <= RESET_PC;
      end else if (sel) begin
         pc_q <= {new_bit, pc_q[31:1]};
      end
   end

   // bit 1 of the target decides misalignment.
   always_ff @(posedge clk) begin
      if (i_reset) begin
         misalign_q <= 1'b0;
      end else if (sel && first_r) begin
         misalign_q <= new_bit;
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         req_q <= 1'b0;
      end else if (i_done) begin
         req_q <= 1'b0;
      end else if (word_end) begin
         req_q <= 1'b1;
      end
   end

   assign o_fetch = '{req: req_q, adr: pc_q, misalign: misalign_q};

endmodule

//--- rtl/ser_add.sv
`timescale 1ns/100ps

module ser_add (
   input  logic clk,
   input  logic i_reset,
   input  logic i_a,
   input  logic i_b,
   input  logic i_clr,
   output logic o_q
);

   logic carry_q;
   logic carry_d;

   assign o_q     = i_a ^ i_b ^ carry_q;
   assign carry_d = (i_a & i_b) | (i_a & carry_q) | (i_b & carry_q);

   // carry starts at zero for every word.
   always_ff @(posedge clk) begin
      if (i_reset || i_clr) begin
         carry_q <= 1'b0;
      end else begin
         carry_q <= carry_d;
      end
   end

endmodule

//--- rtl/serpc_bus_pkg.sv
package serpc_bus_pkg;

   typedef logic [31:0] iadr_t;

   // lane to arbiter, held until the fetch completes.
   typedef struct packed {
      logic  req;
      iadr_t adr;
      logic  misalign;
   } fetch_req_t;

   // completed fetch as reported at the top.
   typedef struct packed {
      serpc_ctrl_pkg::lane_id_t lane;
      iadr_t                    adr;
      logic                     misalign;
   } fetch_rec_t;

endpackage

//--- rtl/serpc_ctrl_pkg.sv
package serpc_ctrl_pkg;

   // one data word, used for offset, base and pc values.
   typedef logic [31:0] xlen_t;

   // lane index, wide enough for four lanes.
   typedef logic [1:0] lane_id_t;

   typedef enum logic [1:0] {
      FLOW_SEQ  = 2'd0,
      FLOW_JUMP = 2'd1,
      FLOW_JALR = 2'd2,
      FLOW_TRAP = 2'd3
   } flow_kind_e;

   // parallel command as it arrives from outside.
   typedef struct packed {
      lane_id_t   lane;
      flow_kind_e kind;
      xlen_t      offset;
      xlen_t      base;
   } cmd_t;

   // one cycle of the serial bus, lsb first.
   typedef struct packed {
      logic       valid;
      logic       first;
      logic       last;
      lane_id_t   lane;
      flow_kind_e kind;
      logic       offset_bit;
      logic       base_bit;
   } ser_stream_t;

endpackage

//--- rtl/serpc_top.sv
`timescale 1ns/100ps

module serpc_top #(
   parameter int                    NUM_LANES = 4,
   parameter serpc_ctrl_pkg::xlen_t RESET_PC  = 32'd8
) (
   input  logic                      clk,
   input  logic                      i_reset,
   input  logic                      i_cmd_valid,
   input  serpc_ctrl_pkg::cmd_t      i_cmd,
   output logic                      o_cmd_ready,
   output logic                      o_ibus_cyc,
   output serpc_bus_pkg::iadr_t      o_ibus_adr,
   input  logic                      i_ibus_ack,
   output logic                      o_fetch_valid,
   output serpc_bus_pkg::fetch_rec_t o_fetch
);

   serpc_ctrl_pkg::ser_stream_t stream;
   serpc_bus_pkg::fetch_req_t   fetch_req [NUM_LANES];
   logic [NUM_LANES-1:0]        done;
   logic [NUM_LANES-1:0]        credit;

   cmd_dispatch #(
      .NUM_LANES (NUM_LANES)
   ) u_dispatch (
      .clk         (clk),
      .i_reset     (i_reset),
      .i_cmd_valid (i_cmd_valid),
      .i_cmd       (i_cmd),
      .o_cmd_ready (o_cmd_ready),
      .i_credit    (credit),
      .o_stream    (stream)
   );

   for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
      pc_lane #(
         .LANE_ID  (i),
         .RESET_PC (RESET_PC)
      ) u_lane (
         .clk      (clk),
         .i_reset  (i_reset),
         .i_stream (stream),
         .i_done   (done[i]),
         .o_fetch  (fetch_req[i])
      );
   end

   fetch_arbiter #(
      .NUM_LANES (NUM_LANES)
   ) u_arbiter (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_req         (fetch_req),
      .o_done        (done),
      .o_credit      (credit),
      .o_ibus_cyc    (o_ibus_cyc),
      .o_ibus_adr    (o_ibus_adr),
      .i_ibus_ack    (i_ibus_ack),
      .o_fetch_valid (o_fetch_valid),
      .o_fetch       (o_fetch)
   );

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
   --top-module serpc_tb \
   -f serpc.f

./obj_dir/Vserpc_tb | tee sim.log

if grep -qx "Regression passed" sim.log; then
   exit 0
fi
echo "simulation did not report a pass"
exit 1

//--- serpc.f
rtl/serpc_ctrl_pkg.sv
rtl/serpc_bus_pkg.sv
rtl/ser_add.sv
rtl/pc_lane.sv
rtl/cmd_dispatch.sv
rtl/fetch_arbiter.sv
rtl/serpc_top.sv
sim/serpc_asserts.sv
sim/serpc_tb.sv

//--- sim/serpc_asserts.sv
`timescale 1ns/100ps

module serpc_asserts #(
   parameter int NUM_LANES = 4
) (
   input logic                        clk,
   input logic                        i_reset,
   input logic                        i_cyc,
   input serpc_bus_pkg::iadr_t        i_adr,
   input logic                        i_ack,
   input logic                        i_fetch_valid,
   input serpc_ctrl_pkg::ser_stream_t i_stream,
   input serpc_bus_pkg::fetch_req_t   i_fetch_req [NUM_LANES],
   input logic [NUM_LANES-1:0]        i_done
);

   logic [NUM_LANES-1:0] req_vec;

   always_comb begin
      for (int i = 0; i < NUM_LANES; i++) begin
         req_vec[i] = i_fetch_req[i].req;
      end
   end

   adr_stable: assert property (@(posedge clk) disable iff (i_reset)
      i_cyc && !i_ack |=> i_cyc && $stable(i_adr))
      else $error("bus address or cycle dropped before ack");

   // the record closes the bus cycle it came from.
   fetch_on_ack: assert property (@(posedge clk) disable iff (i_reset)
      i_fetch_valid |-> i_cyc && i_ack ##1 !i_cyc)
      else $error("fetch record reported outside an ack cycle");

   // a lane with a fetch still pending holds no credit, so gets no bits.
   stream_credit: assert property (@(posedge clk) disable iff (i_reset)
      i_stream.valid |-> !req_vec[i_stream.lane])
      else $error("stream sent to a lane without a credit");

   // grants only go to a lane that is asking.
   one_grant: assert property (@(posedge clk) disable iff (i_reset)
      $onehot0(i_done) && ((i_done & ~req_vec) == '0))
      else $error("more than one lane granted, or a lane granted without a request");

endmodule

//--- sim/serpc_tb.sv
`timescale 1ns/100ps

module serpc_tb;

   localparam int                    NUM_LANES     = 4;
   localparam serpc_ctrl_pkg::xlen_t RESET_PC      = 32'd8;
   localparam int                    CMD_TIMEOUT   = 300;
   localparam int                    DRAIN_TIMEOUT = 1000;
   localparam int                    NUM_RANDOM    = 60;

   logic                      clk = 1'b0;
   logic                      i_reset;
   logic                      i_cmd_valid;
   serpc_ctrl_pkg::cmd_t      i_cmd;
   logic                      o_cmd_ready;
   logic                      o_ibus_cyc;
   serpc_bus_pkg::iadr_t      o_ibus_adr;
   logic                      i_ibus_ack = 1'b0;
   logic                      o_fetch_valid;
   serpc_bus_pkg::fetch_rec_t o_fetch;
   logic [31:0]               stim_rng;
   logic [31:0]               ack_rng = 32'h836;
   int                        ack_base;
   int                        ack_wait = 0;
   logic                      bus_started = 1'b0;
   string                     test_name;
   logic                      timed_out;
   int                        main_errors;
   int                        rec_errors;
   int                        issued;
   int                        received;
   serpc_ctrl_pkg::xlen_t     pc_model [NUM_LANES];
   serpc_bus_pkg::fetch_rec_t exp_q [$];

   serpc_top #(
      .NUM_LANES (NUM_LANES),
      .RESET_PC  (RESET_PC)
   ) dut (.*);

   bind serpc_top serpc_asserts #(
      .NUM_LANES (NUM_LANES)
   ) u_asserts (
      .clk           (clk),
      .i_reset       (i_reset),
      .i_cyc         (o_ibus_cyc),
      .i_adr         (o_ibus_adr),
      .i_ack         (i_ibus_ack),
      .i_fetch_valid (o_fetch_valid),
      .i_stream      (stream),
      .i_fetch_req   (fetch_req),
      .i_done        (done)
   );

   always #4 clk = ~clk;

   function automatic logic [31:0] step_rng(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic logic [31:0] rand_stim();
      stim_rng = step_rng(stim_rng);
      return stim_rng;
   endfunction

   // expected fetch for one command, from the control-flow rules.
   function automatic serpc_bus_pkg::fetch_rec_t expect_rec(input serpc_ctrl_pkg::cmd_t c,
                                                            input serpc_ctrl_pkg::xlen_t pc);
      serpc_ctrl_pkg::xlen_t t;
      case (c.kind)
         serpc_ctrl_pkg::FLOW_SEQ:  t = pc + 32'd4;
         serpc_ctrl_pkg::FLOW_JUMP: t = (pc + c.offset) & ~32'd1;
         serpc_ctrl_pkg::FLOW_JALR: t = (c.base + c.offset) & ~32'd1;
         default:                   t = c.base & ~32'd1;
      endcase
      return '{lane: c.lane, adr: t, misalign: t[1]};
   endfunction

   task automatic report_mismatch(input string what, input int lane,
                                  input logic [31:0] expected, input logic [31:0] actual);
      $display("MISMATCH %s lane %0d %s: expected %h, actual %h",
               test_name, lane, what, expected, actual);
      rec_errors++;
   endtask

   task automatic send_cmd(input int lane, input serpc_ctrl_pkg::flow_kind_e kind,
                           input logic [31:0] offset, input logic [31:0] base);
      int   waited;
      logic accepted;
      waited   = 0;
      accepted = 1'b0;
      if (!timed_out) begin
         @(negedge clk);
         i_cmd.lane   = serpc_ctrl_pkg::lane_id_t'(lane);
         i_cmd.kind   = kind;
         i_cmd.offset = offset;
         i_cmd.base   = base;
         i_cmd_valid  = 1'b1;
         while (!accepted && !timed_out) begin
            @(posedge clk);
            if (o_cmd_ready) begin
               accepted = 1'b1;
            end else if (waited == CMD_TIMEOUT) begin
               $display("timeout: command for lane %0d was never accepted", lane);
               main_errors++;
               timed_out = 1'b1;
            end
            waited++;
         end
         @(negedge clk);
         i_cmd_valid = 1'b0;
      end
   endtask

   task automatic wait_drained();
      int waited;
      waited = 0;
      while (!timed_out && (exp_q.size() != 0 || o_ibus_cyc)) begin
         @(posedge clk);
         if (waited == DRAIN_TIMEOUT) begin
            $display("timeout: %0d fetch records never arrived in %s", exp_q.size(), test_name);
            main_errors++;
            timed_out = 1'b1;
         end
         waited++;
      end
   endtask

   // bus memory, acks each cycle after a random delay.
   always @(negedge clk) begin
      if (i_ibus_ack) begin
         i_ibus_ack  = 1'b0;
         bus_started = 1'b0;
      end else if (o_ibus_cyc) begin
         if (!bus_started) begin
            bus_started = 1'b1;
            ack_rng     = step_rng(ack_rng);
            ack_wait    = ack_base + int'(ack_rng % 32'd6);
         end
         if (ack_wait == 0) begin
            i_ibus_ack = 1'b1;
         end else begin
            ack_wait--;
         end
      end
   end

   // model snoops accepted commands and checks each fetch record.
   always @(posedge clk) begin : model_check
      int                        found;
      serpc_bus_pkg::fetch_rec_t rec;
      found = -1;
      if (i_reset) begin
         for (int i = 0; i < NUM_LANES; i++) begin
            pc_model[i] = RESET_PC;
         end
         exp_q.delete();
         issued     = 0;
         received   = 0;
         rec_errors = 0;
      end else begin
         if (i_cmd_valid && o_cmd_ready) begin
            rec                  = expect_rec(i_cmd, pc_model[i_cmd.lane]);
            pc_model[i_cmd.lane] = rec.adr;
            exp_q.push_back(rec);
            issued++;
         end
         if (o_fetch_valid) begin
            received++;
            if (o_fetch.adr !== o_ibus_adr) begin
               report_mismatch("bus address", int'(o_fetch.lane), o_ibus_adr, o_fetch.adr);
            end
            for (int i = 0; i < exp_q.size(); i++) begin
               if (found < 0 && exp_q[i].lane == o_fetch.lane) begin
                  found = i;
               end
            end
            if (found < 0) begin
               $display("unexpected fetch record from lane %0d at %h", o_fetch.lane, o_fetch.adr);
               rec_errors++;
            end else begin
               if (o_fetch.adr !== exp_q[found].adr) begin
                  report_mismatch("address", int'(o_fetch.lane), exp_q[found].adr, o_fetch.adr);
               end
               if (o_fetch.misalign !== exp_q[found].misalign) begin
                  report_mismatch("misalign", int'(o_fetch.lane),
                                  32'(exp_q[found].misalign), 32'(o_fetch.misalign));
               end
               exp_q.delete(found);
            end
         end
      end
   end

   initial begin : stimulus
      logic [31:0] r;
      i_reset     = 1'b1;
      i_cmd_valid = 1'b0;
      i_cmd       = '0;
      ack_base    = 0;
      stim_rng    = 32'h836;
      timed_out   = 1'b0;
      main_errors = 0;
      test_name   = "reset";
      repeat (2) @(posedge clk);
      @(negedge clk);
      i_reset = 1'b0;
      // bus stays quiet with no command sent.
      repeat (5) begin
         @(posedge clk);
         if (o_ibus_cyc || o_fetch_valid) begin
            $display("MISMATCH %s cyc/valid: expected 0/0, actual %0b/%0b",
                     test_name, o_ibus_cyc, o_fetch_valid);
            main_errors++;
         end
      end

      test_name = "sequential";
      repeat (4) send_cmd(0, serpc_ctrl_pkg::FLOW_SEQ, rand_stim(), rand_stim());
      wait_drained();

      test_name = "jumps";
      // first fetch of lanes 2 and 3 starts from the reset pc.
      send_cmd(2, serpc_ctrl_pkg::FLOW_SEQ, 32'h0, 32'h0);
      send_cmd(3, serpc_ctrl_pkg::FLOW_SEQ, 32'h0, 32'h0);
      send_cmd(1, serpc_ctrl_pkg::FLOW_JUMP, 32'h0000_0123, 32'h0);
      send_cmd(2, serpc_ctrl_pkg::FLOW_JALR, 32'h0000_0011, 32'h8000_0002);
      send_cmd(3, serpc_ctrl_pkg::FLOW_TRAP, 32'h0, 32'h0000_1003);
      send_cmd(3, serpc_ctrl_pkg::FLOW_SEQ, 32'h0, 32'h0);
      send_cmd(1, serpc_ctrl_pkg::FLOW_JUMP, 32'hffff_fff0, 32'h0);
      wait_drained();

      test_name = "random";
      for (int n = 0; n < NUM_RANDOM; n++) begin
         r = rand_stim();
         send_cmd(int'(r[1:0]) % NUM_LANES, serpc_ctrl_pkg::flow_kind_e'(r[3:2]),
                  rand_stim(), rand_stim());
         repeat (int'(r[6:4]) % 4) @(negedge clk);
      end
      wait_drained();

      // long acks keep lane 0 without a credit while a second command waits.
      test_name = "backpressure";
      ack_base  = 60;
      send_cmd(0, serpc_ctrl_pkg::FLOW_JUMP, 32'h40, 32'h0);
      @(negedge clk);
      i_cmd       = '{lane: 2'd0, kind: serpc_ctrl_pkg::FLOW_SEQ, offset: 32'h0, base: 32'h0};
      i_cmd_valid = 1'b1;
      // window runs past the end of the serial word, into the bus cycle.
      repeat (60) begin
         @(posedge clk);
         if (o_cmd_ready) begin
            $display("MISMATCH %s lane 0 ready: expected 0, actual 1", test_name);
            main_errors++;
         end
      end
      @(negedge clk);
      i_cmd_valid = 1'b0;
      send_cmd(1, serpc_ctrl_pkg::FLOW_SEQ, 32'h0, 32'h0);
      if (!timed_out && !o_ibus_cyc) begin
         $display("command for free lane 1 was held until the lane 0 fetch ended");
         main_errors++;
      end
      send_cmd(0, serpc_ctrl_pkg::FLOW_SEQ, 32'h0, 32'h0);
      wait_drained();
      ack_base = 0;

      test_name = "end";
      if (!timed_out && received != issued) begin
         $display("MISMATCH %s record count: expected %0d, actual %0d", test_name, issued, received);
         main_errors++;
      end
      $display("errors %0d, record errors %0d, commands %0d, records %0d",
               main_errors, rec_errors, issued, received);
      if (main_errors == 0 && rec_errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule
